//--- jhp_macros.svh
`ifndef JHP_MACROS_SVH
`define JHP_MACROS_SVH

// --------------------
// Stream format
// --------------------
`define JHP_BYTE_W      8       // Header stream byte

// Marker codes
`define JHP_MK_PREFIX   8'hFF   // Every marker starts with this
`define JHP_MK_SOF0     8'hC0   // Baseline frame header
`define JHP_MK_DQT      8'hDB   // Quantization tables
`define JHP_MK_SOS      8'hDA   // Start of scan

// --------------------
// Table and frame limits
// --------------------
`define JHP_QT_ENTRIES  64      // Entries per quantization table
`define JHP_NUM_QT      2       // Only ids 0 and 1 are kept
`define JHP_MAX_COMP    3       // Y Cb Cr

// Input FIFO depth, also the credits the source holds after reset
`define JHP_CREDITS     4

`endif

//--- jhp_pkg.sv
`include "jhp_macros.svh"

package jhp_pkg;

    // Vector types with a meaning
    typedef logic [`JHP_BYTE_W-1:0]               byte_t;
    typedef logic [15:0]                          seg_len_t;  // Length and remaining count
    typedef logic [15:0]                          dim_t;      // Height or width
    typedef logic [3:0]                           ncomp_t;
    typedef logic [3:0]                           samp_t;     // One sampling factor
    typedef logic [$clog2(`JHP_NUM_QT)-1:0]       qt_id_t;
    typedef logic [$clog2(`JHP_QT_ENTRIES)-1:0]   qt_idx_t;
    typedef logic [1:0]                           comp_idx_t;

    // Marker hunt and segment framing
    typedef enum logic [2:0] {
        HUNT, MARKER_ID, LEN_HI, LEN_LO, BODY
    } scan_state_t;

    // Segment body decode
    typedef enum logic [3:0] {
        SOF_PREC, SOF_H_HI, SOF_H_LO, SOF_W_HI, SOF_W_LO, SOF_NCOMP,
        SOF_C_ID, SOF_C_SAMP, SOF_C_QT, SOF_TAIL,
        DQT_INFO, DQT_READ, SOS_BODY, IGNORE
    } seg_state_t;

endpackage

//--- seg_stream_if.sv
`timescale 1ns/1ns

// Segment body bytes, one per valid cycle, no back-pressure
interface seg_stream_if;

    logic           valid;
    jhp_pkg::byte_t data;     // Body byte
    jhp_pkg::byte_t marker;   // Marker code of the current segment
    logic           first;    // First body byte
    logic           last;     // Final body byte

    modport scanner (
        output valid, data, marker, first, last
    );

    modport decoder (
        input valid, data, marker, first, last
    );

endinterface

//--- qt_write_if.sv
`timescale 1ns/1ns

// Quantization table write port
interface qt_write_if;

    logic             we;
    jhp_pkg::qt_id_t  table_id;   // Stored table 0 or 1
    jhp_pkg::qt_idx_t index;      // Entry in zigzag order
    jhp_pkg::byte_t   data;

    modport writer (
        output we, table_id, index, data
    );

    modport store (
        input we, table_id, index, data
    );

endinterface

//--- byte_intake.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module byte_intake (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           byte_valid,
    input  jhp_pkg::byte_t byte_in,
    input  logic           hold,         // Stop popping once the scan starts
    output logic           pop_valid,
    output jhp_pkg::byte_t pop_data,
    output logic           byte_credit
);

    localparam int DEPTH = `JHP_CREDITS;
    localparam int AW    = $clog2(DEPTH);

    jhp_pkg::byte_t mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;         // Fill level 0..DEPTH
    logic           full;

    assign full        = (count == (AW+1)'(DEPTH));
    assign pop_valid   = (count != '0) && !hold;
    assign pop_data    = mem[rd_ptr];
    assign byte_credit = pop_valid;   // One credit back per consumed byte

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (byte_valid)
            mem[wr_ptr] <= byte_in;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (byte_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_valid)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(byte_valid) - (AW+1)'(pop_valid);
        end
    end

    // Source must hold a credit for every byte it sends
    a_no_overrun : assert property (
        @(posedge clk) disable iff (!rst_n) byte_valid |-> !full
    );

endmodule

//--- marker_scanner.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module marker_scanner (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pop_valid,
    input  jhp_pkg::byte_t pop_data,
    seg_stream_if.scanner  seg
);

    jhp_pkg::scan_state_t state;
    jhp_pkg::seg_len_t    rem_cnt;     // High length byte, then body bytes left
    jhp_pkg::seg_len_t    seg_len;
    logic                 body_first;
    logic                 standalone;

    assign seg_len = {rem_cnt[15:8], pop_data};
    // SOI, EOI, RSTn and TEM carry no length field
    assign standalone = (pop_data == 8'h01) || (pop_data >= 8'hD0 && pop_data <= 8'hD9);

    // --------------------
    // Hunt and framing FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= jhp_pkg::HUNT;
            rem_cnt    <= '0;
            body_first <= 1'b0;
            seg.valid  <= 1'b0;
            seg.first  <= 1'b0;
            seg.last   <= 1'b0;
        end else begin
            seg.valid <= 1'b0;
            seg.first <= 1'b0;
            seg.last  <= 1'b0;
            if (pop_valid) begin
                case (state)
                    jhp_pkg::HUNT: if (pop_data == `JHP_MK_PREFIX) state <= jhp_pkg::MARKER_ID;
                    jhp_pkg::MARKER_ID: begin
                        if (pop_data == 8'h00 || standalone)
                            state <= jhp_pkg::HUNT;       // Stuffed zero or bare marker
                        else if (pop_data != `JHP_MK_PREFIX)
                            state <= jhp_pkg::LEN_HI;     // FF fill keeps us here
                    end
                    jhp_pkg::LEN_HI: begin
                        rem_cnt[15:8] <= pop_data;
                        state         <= jhp_pkg::LEN_LO;
                    end
                    jhp_pkg::LEN_LO: begin
                        rem_cnt    <= seg_len - 16'd2;   // Length counts its own two bytes
                        body_first <= 1'b1;
                        state      <= (seg_len > 16'd2) ? jhp_pkg::BODY : jhp_pkg::HUNT;
                    end
                    jhp_pkg::BODY: begin
                        seg.valid  <= 1'b1;
                        seg.first  <= body_first;
                        seg.last   <= (rem_cnt == 16'd1);
                        body_first <= 1'b0;
                        rem_cnt    <= rem_cnt - 16'd1;
                        if (rem_cnt == 16'd1)
                            state <= jhp_pkg::HUNT;
                    end
                    default: state <= jhp_pkg::HUNT;
                endcase
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        seg.data <= pop_data;
        if (pop_valid && state == jhp_pkg::MARKER_ID)
            seg.marker <= pop_data;
    end

    // Body framing never runs with the byte count used up
    a_body_count_live : assert property (
        @(posedge clk) disable iff (!rst_n) state == jhp_pkg::BODY |-> rem_cnt != '0
    );

endmodule

//--- segment_decoder.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module segment_decoder (
    input  logic             clk,
    input  logic             rst_n,
    seg_stream_if.decoder    seg,
    qt_write_if.writer       qtw,
    output jhp_pkg::dim_t    img_height,
    output jhp_pkg::dim_t    img_width,
    output jhp_pkg::ncomp_t  num_components,
    output jhp_pkg::samp_t   comp_h_samp [`JHP_MAX_COMP],
    output jhp_pkg::samp_t   comp_v_samp [`JHP_MAX_COMP],
    output jhp_pkg::qt_id_t  comp_quant_id [`JHP_MAX_COMP],
    output logic             start_scan
);

    jhp_pkg::seg_state_t state;
    jhp_pkg::seg_state_t cur_state;    // State that owns the byte on the stream
    jhp_pkg::comp_idx_t  comp_cnt;
    jhp_pkg::qt_id_t     dqt_id;
    logic                dqt_keep;     // Table id fits the store
    jhp_pkg::qt_idx_t    dqt_idx;
    logic                last_comp;

    // First byte of a segment selects the decode path from the marker
    always_comb begin
        cur_state = state;
        if (seg.first) begin
            case (seg.marker)
                `JHP_MK_SOF0: cur_state = jhp_pkg::SOF_PREC;
                `JHP_MK_DQT:  cur_state = jhp_pkg::DQT_INFO;
                `JHP_MK_SOS:  cur_state = jhp_pkg::SOS_BODY;
                default:      cur_state = jhp_pkg::IGNORE;     // APPn, COM and the rest
            endcase
        end
    end

    assign last_comp = (comp_cnt == 2'(`JHP_MAX_COMP - 1)) ||
                       (jhp_pkg::ncomp_t'(comp_cnt) + 4'd1 >= num_components);

    // --------------------
    // Body decode
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= jhp_pkg::IGNORE;
            img_height     <= '0;
            img_width      <= '0;
            num_components <= '0;
            comp_cnt       <= '0;
            dqt_id         <= '0;
            dqt_keep       <= 1'b0;
            dqt_idx        <= '0;
            start_scan     <= 1'b0;
            qtw.we         <= 1'b0;
            for (int i = 0; i < `JHP_MAX_COMP; i++) begin
                comp_h_samp[i]   <= '0;
                comp_v_samp[i]   <= '0;
                comp_quant_id[i] <= '0;
            end
        end else begin
            qtw.we <= 1'b0;
            if (seg.valid) begin
                case (cur_state)
                    jhp_pkg::SOF_PREC:  state <= jhp_pkg::SOF_H_HI;   // Precision unused
                    jhp_pkg::SOF_H_HI: begin
                        img_height[15:8] <= seg.data;
                        state            <= jhp_pkg::SOF_H_LO;
                    end
                    jhp_pkg::SOF_H_LO: begin
                        img_height[7:0] <= seg.data;
                        state           <= jhp_pkg::SOF_W_HI;
                    end
                    jhp_pkg::SOF_W_HI: begin
                        img_width[15:8] <= seg.data;
                        state           <= jhp_pkg::SOF_W_LO;
                    end
                    jhp_pkg::SOF_W_LO: begin
                        img_width[7:0] <= seg.data;
                        state          <= jhp_pkg::SOF_NCOMP;
                    end
                    jhp_pkg::SOF_NCOMP: begin
                        num_components <= seg.data[3:0];
                        comp_cnt       <= '0;
                        state <= (seg.data[3:0] == 4'd0) ? jhp_pkg::SOF_TAIL : jhp_pkg::SOF_C_ID;
                    end
                    jhp_pkg::SOF_C_ID:  state <= jhp_pkg::SOF_C_SAMP;  // Component id unused
                    jhp_pkg::SOF_C_SAMP: begin
                        comp_h_samp[comp_cnt] <= seg.data[7:4];
                        comp_v_samp[comp_cnt] <= seg.data[3:0];
                        state                 <= jhp_pkg::SOF_C_QT;
                    end
                    jhp_pkg::SOF_C_QT: begin
                        comp_quant_id[comp_cnt] <= seg.data[0];
                        comp_cnt                <= comp_cnt + 2'd1;
                        state <= last_comp ? jhp_pkg::SOF_TAIL : jhp_pkg::SOF_C_ID;
                    end
                    jhp_pkg::DQT_INFO: begin
                        dqt_id   <= seg.data[0];
                        dqt_keep <= (seg.data[3:0] < 4'(`JHP_NUM_QT));
                        dqt_idx  <= '0;
                        state    <= jhp_pkg::DQT_READ;
                    end
                    jhp_pkg::DQT_READ: begin
                        qtw.we  <= dqt_keep;             // Higher ids are dropped
                        dqt_idx <= dqt_idx + 1'b1;
                        if (dqt_idx == 6'(`JHP_QT_ENTRIES - 1))
                            state <= seg.last ? jhp_pkg::IGNORE : jhp_pkg::DQT_INFO;
                    end
                    jhp_pkg::SOS_BODY: begin
                        state <= jhp_pkg::SOS_BODY;
                        if (seg.last)
                            start_scan <= 1'b1;          // Sticky until reset
                    end
                    default: state <= cur_state;         // SOF_TAIL and IGNORE just drain
                endcase
            end
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        qtw.table_id <= dqt_id;
        qtw.index    <= dqt_idx;
        qtw.data     <= seg.data;
    end

    // Table writes only come out of a DQT segment body
    a_write_from_dqt : assert property (
        @(posedge clk) disable iff (!rst_n)
        qtw.we |-> $past(seg.marker) == `JHP_MK_DQT
    );

endmodule

//--- qt_store.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module qt_store (
    input  logic             clk,
    input  logic             rst_n,
    qt_write_if.store        qtw,
    input  jhp_pkg::qt_id_t  qt_rd_table,
    input  jhp_pkg::qt_idx_t qt_rd_index,
    output jhp_pkg::byte_t   qt_rd_data
);

    // Two tables of 64 entries each
    jhp_pkg::byte_t mem [`JHP_NUM_QT][`JHP_QT_ENTRIES];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (qtw.we)
            mem[qtw.table_id][qtw.index] <= qtw.data;
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            qt_rd_data <= '0;
        else
            qt_rd_data <= mem[qt_rd_table][qt_rd_index];
    end

endmodule

//--- jpeg_header_parser.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module jpeg_header_parser (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             byte_valid,
    input  jhp_pkg::byte_t   byte_in,
    output logic             byte_credit,
    output jhp_pkg::dim_t    img_height,
    output jhp_pkg::dim_t    img_width,
    output jhp_pkg::ncomp_t  num_components,
    output jhp_pkg::samp_t   comp_h_samp [`JHP_MAX_COMP],
    output jhp_pkg::samp_t   comp_v_samp [`JHP_MAX_COMP],
    output jhp_pkg::qt_id_t  comp_quant_id [`JHP_MAX_COMP],
    output logic             start_scan,
    input  jhp_pkg::qt_id_t  qt_rd_table,
    input  jhp_pkg::qt_idx_t qt_rd_index,
    output jhp_pkg::byte_t   qt_rd_data
);

    logic           pop_valid;
    jhp_pkg::byte_t pop_data;

    seg_stream_if seg_stream_if_inst ();   // Scanner to decoder
    qt_write_if   qt_write_if_inst ();     // Decoder to table store

    // --------------------
    // Input side
    // --------------------
    byte_intake byte_intake_inst (
        .clk, .rst_n, .byte_valid, .byte_in,
        .hold (start_scan),                // Scan data is left for the next stage
        .pop_valid, .pop_data, .byte_credit
    );

    marker_scanner marker_scanner_inst (
        .clk, .rst_n, .pop_valid, .pop_data, .seg (seg_stream_if_inst.scanner)
    );

    segment_decoder segment_decoder_inst (
        .clk, .rst_n, .seg (seg_stream_if_inst.decoder), .qtw (qt_write_if_inst.writer),
        .img_height, .img_width, .num_components,
        .comp_h_samp, .comp_v_samp, .comp_quant_id, .start_scan
    );

    // Table readback
    qt_store qt_store_inst (
        .clk, .rst_n, .qtw (qt_write_if_inst.store),
        .qt_rd_table, .qt_rd_index, .qt_rd_data
    );

endmodule

//--- tb_jpeg_header_parser.sv
`timescale 1ns/1ns
`include "jhp_macros.svh"

module tb_jpeg_header_parser;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             byte_valid;
    jhp_pkg::byte_t   byte_in;
    logic             byte_credit;
    jhp_pkg::dim_t    img_height;
    jhp_pkg::dim_t    img_width;
    jhp_pkg::ncomp_t  num_components;
    jhp_pkg::samp_t   comp_h_samp [`JHP_MAX_COMP];
    jhp_pkg::samp_t   comp_v_samp [`JHP_MAX_COMP];
    jhp_pkg::qt_id_t  comp_quant_id [`JHP_MAX_COMP];
    logic             start_scan;
    jhp_pkg::qt_id_t  qt_rd_table;
    jhp_pkg::qt_idx_t qt_rd_index;
    jhp_pkg::byte_t   qt_rd_data;

    // Trace contents
    jhp_pkg::byte_t   stim_q [$];             // Header bytes in stream order
    int               zero_at = -1;           // Stream position of the idle check
    jhp_pkg::dim_t    exp_h;
    jhp_pkg::dim_t    exp_w;
    jhp_pkg::ncomp_t  exp_n;
    jhp_pkg::samp_t   exp_hs [`JHP_MAX_COMP];
    jhp_pkg::samp_t   exp_vs [`JHP_MAX_COMP];
    jhp_pkg::qt_id_t  exp_qid [`JHP_MAX_COMP];
    jhp_pkg::byte_t   exp_qt [`JHP_NUM_QT][`JHP_QT_ENTRIES];

    integer seed = 22762;
    int     credits;                          // Source side credit count
    int     cycles = 0;
    int     cycle_limit = 0;
    int     check_errs = 0;
    int     credit_errs = 0;
    int     timeout_errs = 0;
    int     k;

    always #2 clk = ~clk;

    jpeg_header_parser jpeg_header_parser_inst (
        .clk, .rst_n, .byte_valid, .byte_in, .byte_credit,
        .img_height, .img_width, .num_components,
        .comp_h_samp, .comp_v_samp, .comp_quant_id, .start_scan,
        .qt_rd_table, .qt_rd_index, .qt_rd_data
    );

    task automatic finish_run();
        $display("check errors %0d, credit errors %0d, timeouts %0d",
                 check_errs, credit_errs, timeout_errs);
        if (check_errs + credit_errs + timeout_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        check_errs++;
        $display("error %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic check_dim(input string name, input jhp_pkg::dim_t expected,
                             input jhp_pkg::dim_t actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    task automatic check_ncomp(input string name, input jhp_pkg::ncomp_t expected,
                               input jhp_pkg::ncomp_t actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    task automatic check_samp(input string name, input jhp_pkg::samp_t expected,
                              input jhp_pkg::samp_t actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    task automatic check_qid(input string name, input jhp_pkg::qt_id_t expected,
                             input jhp_pkg::qt_id_t actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    task automatic check_qval(input string name, input jhp_pkg::byte_t expected,
                              input jhp_pkg::byte_t actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    // Tags are one character, data tokens are two hex digits
    task automatic load_trace();
        int          fd;
        int          r;
        int          tbl;
        int          idx;
        int          ci;
        int          qv;
        logic [15:0] val;
        logic [3:0]  hs;
        logic [3:0]  vs;
        string       tok;
        string       line;
        string       mode;
        fd   = $fopen("jhp_trace.txt", "r");
        mode = "B";
        tbl  = 0;
        idx  = 0;
        if (fd == 0) begin
            $display("trace file jhp_trace.txt could not be opened");
            check_errs++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#")
                    r = $fgets(line, fd);                 // Skip rest of comment
                else if (tok == "B")
                    mode = "B";
                else if (tok == "Q") begin
                    mode = "Q";
                    r    = $fscanf(fd, "%d %d", tbl, idx);
                end else if (tok == "Z")
                    zero_at = stim_q.size();
                else if (tok == "H")
                    r = $fscanf(fd, "%h", exp_h);
                else if (tok == "W")
                    r = $fscanf(fd, "%h", exp_w);
                else if (tok == "N")
                    r = $fscanf(fd, "%h", exp_n);
                else if (tok == "C") begin
                    r           = $fscanf(fd, "%d %h %h %h", ci, hs, vs, qv);
                    exp_hs[ci]  = hs;
                    exp_vs[ci]  = vs;
                    exp_qid[ci] = qv[0];
                end else begin
                    r = $sscanf(tok, "%h", val);
                    if (mode == "B")
                        stim_q.push_back(val[7:0]);
                    else begin
                        exp_qt[tbl][idx] = val[7:0];
                        idx++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // Credit-respecting driver
    // --------------------
    // Credit seen this cycle is spent from the next cycle on
    task automatic drive_cycle(input logic send, input jhp_pkg::byte_t b);
        logic crd;
        @(negedge clk);
        crd        = byte_credit;
        byte_valid = send;
        byte_in    = b;
        if (crd && start_scan) begin
            credit_errs++;
            $display("credit returned after start_scan at %0t", $time);
        end
        credits = credits - int'(send) + int'(crd);
        if (credits > `JHP_CREDITS) begin
            credit_errs++;
            $display("source holds %0d credits at %0t, more than the FIFO depth",
                     credits, $time);
        end
    endtask

    // Let the FIFO empty and the pipeline settle, frame outputs must be idle
    task automatic check_idle_outputs();
        while (credits < `JHP_CREDITS)
            drive_cycle(1'b0, 8'h00);
        repeat (3) drive_cycle(1'b0, 8'h00);     // Scanner and decoder stages
        check_dim("img_height", '0, img_height);
        check_dim("img_width", '0, img_width);
        check_ncomp("num_components", '0, num_components);
    endtask

    task automatic check_frame();
        check_dim("img_height", exp_h, img_height);
        check_dim("img_width", exp_w, img_width);
        check_ncomp("num_components", exp_n, num_components);
        for (int c = 0; c < `JHP_MAX_COMP; c++) begin
            check_samp($sformatf("comp_h_samp[%0d]", c), exp_hs[c], comp_h_samp[c]);
            check_samp($sformatf("comp_v_samp[%0d]", c), exp_vs[c], comp_v_samp[c]);
            check_qid($sformatf("comp_quant_id[%0d]", c), exp_qid[c], comp_quant_id[c]);
        end
    endtask

    // One cycle read latency, address on one falling edge, data at the next
    task automatic read_back_tables();
        for (int t = 0; t < `JHP_NUM_QT; t++) begin
            for (int i = 0; i < `JHP_QT_ENTRIES; i++) begin
                @(negedge clk);
                qt_rd_table = jhp_pkg::qt_id_t'(t);
                qt_rd_index = jhp_pkg::qt_idx_t'(i);
                @(negedge clk);
                check_qval($sformatf("qt_rd_data[%0d][%0d]", t, i), exp_qt[t][i], qt_rd_data);
            end
        end
    endtask

    // Cycle budget follows the trace length
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, header not finished within %0d cycles", cycle_limit);
            timeout_errs++;
            finish_run();
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_n       = 1'b0;
        byte_valid  = 1'b0;
        byte_in     = '0;
        qt_rd_table = '0;
        qt_rd_index = '0;
        credits     = `JHP_CREDITS;
        load_trace();
        cycle_limit = 20 * stim_q.size() + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        k = 0;
        while (k < stim_q.size() && !start_scan) begin
            if (k == zero_at) begin
                check_idle_outputs();             // Skipped segments change nothing
                zero_at = -1;
            end
            if (credits > 0 && ($random(seed) % 4) != 0) begin
                drive_cycle(1'b1, stim_q[k]);
                k++;
            end else
                drive_cycle(1'b0, 8'h00);         // Random idle gap
        end
        while (!start_scan)
            drive_cycle(1'b0, 8'h00);

        // Scan data goes in on the credits left, none may come back
        while (credits > 0 && k < stim_q.size()) begin
            drive_cycle(1'b1, stim_q[k]);
            k++;
        end
        repeat (20) drive_cycle(1'b0, 8'h00);

        check_frame();
        read_back_tables();
        finish_run();
    end

endmodule

//--- jhp_trace.txt
# B stream bytes in hex, Z drain then check that frame outputs are still zero
# H W N height width count in hex, C comp h_samp v_samp qt_id, Q table start_index entries
B ff d8 ff e0 00 10 4a 46 49 46 00 01 01 00 00 01 00 01 00 00
B ff ff 00 ff fe 00 06 61 62 63 64
Z
B ff ff c0 00 11 08 00 30 00 40 03 01 21 00 02 11 01 03 12 01
B ff db 00 84 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
B 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28
B 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40
B 01 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
B 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f a0 a1 a2 a3 a4 a5 a6 a7
B a8 a9 aa ab ac ad ae af b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
B ff db 00 43 02 ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee
B ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee
B ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee ee
B ff da 00 0c 03 01 00 02 11 03 11 00 3f 00 12 34 56 78 9a bc ff d9
H 0030 W 0040 N 3
C 0 2 1 0
C 1 1 1 1
C 2 1 2 1
Q 0 0 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18
Q 0 24 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30
Q 0 48 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40
Q 1 0 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93 94 95 96 97
Q 1 24 98 99 9a 9b 9c 9d 9e 9f a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
Q 1 48 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf

//--- vlog.f
+incdir+.
jhp_pkg.sv
seg_stream_if.sv
qt_write_if.sv
byte_intake.sv
marker_scanner.sv
segment_decoder.sv
qt_store.sv
jpeg_header_parser.sv
tb_jpeg_header_parser.sv

//--- Bender.yml
package:
  name: jpeg_header_parser

export_include_dirs:
  - .

sources:
  - jhp_pkg.sv
  - seg_stream_if.sv
  - qt_write_if.sv
  - byte_intake.sv
  - marker_scanner.sv
  - segment_decoder.sv
  - qt_store.sv
  - jpeg_header_parser.sv
  - target: test
    files:
      - tb_jpeg_header_parser.sv
